// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found on the PATH"
  exit 1
fi

verilator --binary --timing --assert -j 0 --top-module tb_vlsu -f verilog.f -o tb_vlsu_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_vlsu_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1

// File: tb_vlsu.sv
`timescale 1ns/1ps

module tb_vlsu;

  import vlsu_pkg::*;

  // all requests together stay under 200 cycles, even with the longest dhit delays.
  localparam int TIMEOUT_CYCLES = 2000;

  logic         CLK = 1'b0;
  logic         nRST;
  logic         start;
  logic         is_store;
  logic         exc_ack;
  logic [31:0]  base_addr;
  logic [31:0]  stride;
  sew_t         sew;
  logic [3:0]   vl;
  logic [255:0] st_vec;
  logic         dhit = 1'b0;
  logic [31:0]  rdata = '0;
  logic         busy;
  logic         exception;
  logic         ren;
  logic         wen;
  logic         vd_wen;
  logic [31:0]  dcache_addr;
  logic [31:0]  dcache_wdata;
  logic [31:0]  vd_wdata;
  logic [3:0]   dcache_byte_en;
  logic [3:0]   vd_idx;

  // own copy of the running request, kept apart from the DUT inputs.
  logic         cur_store;
  logic [31:0]  cur_base;
  logic [31:0]  cur_stride;
  sew_t         cur_sew;
  logic [3:0]   cur_vl;
  int           req_id;    // requests launched that must run to the end.
  int           done_id;   // requests that the checker saw finish.
  int           done_cnt;  // elements finished in the running request.
  logic         exc_exp;   // an exception is expected in this cycle.
  logic [7:0]   mem [256];
  logic [7:0]   ref_mem [256];
  logic [31:0]  lat_rng = 32'hfd67; // dhit latency stream of the memory model.
  logic [31:0]  vec_rng;            // store data stream, same seed.
  logic         pending;
  int           wait_left;
  int           cycles = 0;

  vlsu_top u_vlsu_top (.*);

  always #5 CLK = ~CLK; // 10 ns period.

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // an odd multiplier makes every address bit count in the fill byte.
  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a * 37 + 11);
  endfunction

  function automatic int sew_bytes(input sew_t w);
    case (w)
      SEW8:    return 1;
      SEW16:   return 2;
      default: return 4;
    endcase
  endfunction

  // little-endian element read from the reference copy, zero-extended.
  function automatic logic [31:0] load_value(input logic [31:0] addr, input sew_t w);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < sew_bytes(w); k++)
      v[8*k +: 8] = ref_mem[8'(addr + 32'(k))];
    return v;
  endfunction

  function automatic logic [3:0] lane_enables(input logic [31:0] addr, input sew_t w);
    logic [3:0] en;
    case (w)
      SEW8:    en = 4'b0001;
      SEW16:   en = 4'b0011;
      default: en = 4'b1111;
    endcase
    return en << addr[1:0]; // the element sits at its byte offset in the word.
  endfunction

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
    $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, want);
    $display("Test failed");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopping the run");
  endtask

  always @(posedge CLK)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
      abort_run($sformatf("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  // memory model. dhit comes 0 to 3 cycles after the strobe and writes land at the falling edge.
  always @(posedge CLK)
  begin
    #1;
    if (!nRST)
    begin
      for (int i = 0; i < 256; i++)
        mem[i] = fill_byte(i);
      dhit    = 1'b0;
      pending = 1'b0;
    end
    else
    begin
      if (dhit)
        pending = 1'b0; // the access ended at this edge.
      dhit = 1'b0;
      if ((ren || wen) && !pending)
      begin
        lat_rng   = xorshift32(lat_rng);
        wait_left = int'(lat_rng[1:0]);
        pending   = 1'b1;
      end
      if (pending && wait_left == 0)
      begin
        dhit  = 1'b1;
        rdata = {mem[{dcache_addr[7:2], 2'd3}], mem[{dcache_addr[7:2], 2'd2}],
                 mem[{dcache_addr[7:2], 2'd1}], mem[{dcache_addr[7:2], 2'd0}]};
      end
      else if (pending)
        wait_left = wait_left - 1;
      @(negedge CLK);
      for (int k = 0; k < 4; k++)
        if (wen && dhit && dcache_byte_en[k])
          mem[{dcache_addr[7:2], 2'(k)}] = dcache_wdata[8*k +: 8];
    end
  end

  // checker. everything is sampled at the falling edge, well after the inputs settle.
  always @(negedge CLK)
  begin
    logic [31:0] addr_exp;
    logic        running;
    logic        busy_exp;
    logic        vd_wen_exp;
    if (!nRST)
    begin
      for (int i = 0; i < 256; i++)
        ref_mem[i] = fill_byte(i);
      done_cnt = 0;
      done_id  = 0;
    end
    else
    begin
      running    = (req_id != done_id);
      busy_exp   = running && !(dhit && (done_cnt + 1 == int'(cur_vl))); // falls on the last dhit.
      vd_wen_exp = running && dhit && !cur_store; // a load writes back on every dhit.
      assert (busy == busy_exp) else value_mismatch("busy", 32'(busy), 32'(busy_exp));
      assert (exception == exc_exp)
        else value_mismatch("exception", 32'(exception), 32'(exc_exp));
      assert ((ren || wen) == running)
        else abort_run("cache strobe does not match the request that should be running");
      assert (vd_wen == vd_wen_exp) else value_mismatch("vd_wen", 32'(vd_wen), 32'(vd_wen_exp));
      if (running && dhit)
      begin
        addr_exp = cur_base + 32'(done_cnt) * cur_stride; // element i lives at base + i*stride.
        assert (wen == cur_store) else value_mismatch("wen", 32'(wen), 32'(cur_store));
        assert (dcache_addr == addr_exp) else value_mismatch("dcache_addr", dcache_addr, addr_exp);
        if (cur_store)
        begin
          assert (dcache_byte_en == lane_enables(addr_exp, cur_sew))
            else value_mismatch("dcache_byte_en", 32'(dcache_byte_en),
                                32'(lane_enables(addr_exp, cur_sew)));
          for (int k = 0; k < sew_bytes(cur_sew); k++)
            ref_mem[8'(addr_exp + 32'(k))] = st_vec[32*done_cnt + 8*k +: 8];
        end
        else
        begin
          assert (vd_idx == 4'(done_cnt)) else value_mismatch("vd_idx", 32'(vd_idx), done_cnt);
          assert (vd_wdata == load_value(addr_exp, cur_sew))
            else value_mismatch("vd_wdata", vd_wdata, load_value(addr_exp, cur_sew));
        end
        if (done_cnt + 1 == int'(cur_vl))
        begin
          done_cnt = 0;
          done_id  = done_id + 1;
        end
        else
          done_cnt = done_cnt + 1;
      end
    end
  end

  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  task automatic launch(input logic store, input logic [31:0] base, input logic [31:0] strd,
                        input sew_t w, input logic [3:0] n);
    cur_store  = store;
    cur_base   = base;
    cur_stride = strd;
    cur_sew    = w;
    cur_vl     = n;
    is_store   = store;
    base_addr  = base;
    stride     = strd;
    sew        = w;
    vl         = n;
    start      = 1'b1; // one-cycle pulse.
    step();
    start = 1'b0;
  endtask

  task automatic wait_done();
    while (req_id != done_id)
      step();
  endtask

  task automatic compare_memory();
    for (int i = 0; i < 256; i++)
      assert (mem[i] == ref_mem[i])
        else value_mismatch($sformatf("mem[0x%02h]", i), 32'(mem[i]), 32'(ref_mem[i]));
  endtask

  task automatic run_request(input logic store, input logic [31:0] base, input logic [31:0] strd,
                             input sew_t w, input logic [3:0] n);
    if (store)
      for (int i = 0; i < VLMAX; i++)
      begin
        vec_rng = xorshift32(vec_rng);
        st_vec[32*i +: 32] = vec_rng;
      end
    launch(store, base, strd, w, n);
    req_id = req_id + 1; // the checker now expects this request's strobes.
    wait_done();
    if (store)
      compare_memory();
  endtask

  initial
  begin
    nRST      = 1'b0;
    start     = 1'b0;
    is_store  = 1'b0;
    exc_ack   = 1'b0;
    base_addr = '0;
    stride    = '0;
    sew       = SEW8;
    vl        = '0;
    st_vec    = '0;
    cur_store = 1'b0;
    cur_sew   = SEW8;
    cur_vl    = '0;
    req_id    = 0;
    exc_exp   = 1'b0;
    vec_rng   = 32'hfd67;
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;
    step();
    run_request(1'b0, 32'h10, 32'd4, SEW32, 4'd8); // unit-stride words.
    run_request(1'b0, 32'h45, 32'd3, SEW8, 4'd7);  // stride of 3 bytes with an odd tail.
    run_request(1'b1, 32'h22, 32'd6, SEW16, 4'd4); // halfwords in both lanes.
    run_request(1'b1, 32'h61, 32'd5, SEW8, 4'd5);  // five writes with the last one alone.
    // a misaligned word base goes to EX and never reaches the cache.
    launch(1'b0, 32'h42, 32'd4, SEW32, 4'd4);
    exc_exp = 1'b1;
    repeat (3) step();
    exc_ack = 1'b1;
    step();
    exc_ack = 1'b0;
    exc_exp = 1'b0;
    step();
    run_request(1'b0, 32'h44, 32'd8, SEW32, 4'd4);
    // a second start in the middle of a load must be dropped.
    launch(1'b0, 32'h20, 32'd2, SEW16, 4'd6);
    req_id = req_id + 1;
    step();
    is_store  = 1'b1;
    base_addr = 32'h0;
    start     = 1'b1;
    step();
    start = 1'b0;
    wait_done();
    repeat (4) step(); // a late access from the dropped start would show here.
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: verilog.f
vlsu_pkg.sv
vlsu_addr_gen.sv
vlsu_address_scheduler.sv
vlsu_load_collect.sv
vlsu_store_pack.sv
vlsu_top.sv
vlsu_props.sv
tb_vlsu.sv

// File: vlsu_addr_gen.sv
`timescale 1ns/1ps

module vlsu_addr_gen (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        start,
  input  logic [vlsu_pkg::ADDR_W-1:0] base_addr,
  input  logic [vlsu_pkg::ADDR_W-1:0] stride,
  input  logic [vlsu_pkg::VL_W-1:0]   vl,
  input  logic                        pair_advance,
  output logic [vlsu_pkg::ADDR_W-1:0] addr0,
  output logic [vlsu_pkg::ADDR_W-1:0] addr1,
  output logic [vlsu_pkg::VL_W-1:0]   woffset0,
  output logic [vlsu_pkg::VL_W-1:0]   woffset1,
  output logic                        last_pair
);

  import vlsu_pkg::*;

  logic [ADDR_W-1:0] pair_q;     // address of the even element of the current pair.
  logic [ADDR_W-1:0] stride_q;   // byte stride of the running request.
  logic [ADDR_W-1:0] stride_now; // stride seen by addr1 in this cycle.
  logic [VL_W-1:0]   woff_q;     // index of the even element of the current pair.
  logic [VL_W-1:0]   vl_q;       // vector length of the running request.
  logic [VL_W:0]     pair_end;   // one past the odd element, one bit wider.

  // element offset and vector length of the running request.
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      woff_q <= '0;
      vl_q   <= '0;
    end
    else if (start)
    begin
      woff_q <= '0; // every request starts at element 0.
      vl_q   <= vl;
    end
    else if (pair_advance)
    begin
      woff_q <= woff_q + VL_W'(2); // step over both elements of the pair.
    end
  end

  // address of the current pair and the stride between elements.
  always_ff @(posedge CLK)
  begin
    if (start)
    begin
      pair_q   <= base_addr;
      stride_q <= stride;
    end
    else if (pair_advance)
    begin
      pair_q <= pair_q + (stride_q << 1); // next pair lies two strides further.
    end
  end

  // during the start cycle the incoming request is passed straight through.
  // That lets the scheduler check the first pair for alignment before it is issued.
  assign addr0      = start ? base_addr : pair_q;
  assign stride_now = start ? stride : stride_q;
  assign addr1      = addr0 + stride_now; // odd element is one stride above the even one.

  assign woffset0 = woff_q;
  assign woffset1 = woff_q + VL_W'(1);

  // the pair is the final one once its odd slot reaches or passes vl.
  // For an odd vl that slot is past the end and gets skipped by the scheduler.
  assign pair_end  = {1'b0, woffset1} + (VL_W+1)'(1);
  assign last_pair = (pair_end >= {1'b0, vl_q});

endmodule

// File: vlsu_address_scheduler.sv
`timescale 1ns/1ps

module vlsu_address_scheduler (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        start,
  input  logic                        is_store,
  input  vlsu_pkg::sew_t              sew,
  input  logic [vlsu_pkg::VL_W-1:0]   vl,
  input  logic [vlsu_pkg::ADDR_W-1:0] addr0,
  input  logic [vlsu_pkg::ADDR_W-1:0] addr1,
  input  logic [vlsu_pkg::VL_W-1:0]   woffset1,
  input  logic                        last_pair,
  input  logic                        dhit,
  input  logic                        exc_ack,
  output logic [vlsu_pkg::ADDR_W-1:0] dcache_addr,
  output logic                        ren,
  output logic                        wen,
  output logic                        busy,
  output logic                        exception,
  output logic                        arrived,
  output logic                        elem_sel,
  output logic                        pair_advance,
  output vlsu_pkg::sew_t              sew_q
);

  import vlsu_pkg::*;

  sched_state_t    state;
  sched_state_t    next_state;
  logic [VL_W-1:0] vl_q;
  logic            in_pair0;  // even element of a pair is on the port.
  logic            in_pair1;  // odd element of a pair is on the port.
  logic            odd_tail;  // the odd slot of this pair lies past vl.
  logic            final_hit; // this dhit completes the whole request.
  logic [1:0]      stride_lo;
  logic [1:0]      next_lo0;
  logic [1:0]      next_lo1;
  logic            has_next1;
  logic            mis_first;
  logic            mis_next;

  // an element must sit on a multiple of its own size.
  function automatic logic misaligned(input sew_t width, input logic [1:0] lo);
    case (width)
      SEW16:   misaligned = lo[0];
      SEW32:   misaligned = (lo != 2'b00);
      default: misaligned = 1'b0; // bytes are always aligned.
    endcase
  endfunction

  // the first pair is checked at start, on the fresh sew and on the addresses passed through.
  // Its odd element only counts when vl asks for more than one element.
  assign mis_first = misaligned(sew, addr0[1:0])
                   | ((vl > VL_W'(1)) & misaligned(sew, addr1[1:0]));

  // only the low two address bits matter here, and the stride is addr1 minus addr0.
  // So the next pair's low bits follow from the current pair alone.
  assign stride_lo = addr1[1:0] - addr0[1:0];
  assign next_lo0  = addr1[1:0] + stride_lo;
  assign next_lo1  = next_lo0 + stride_lo;
  assign has_next1 = (woffset1 + VL_W'(2)) < vl_q; // odd element of the next pair exists.
  assign mis_next  = misaligned(sew_q, next_lo0) | (has_next1 & misaligned(sew_q, next_lo1));

  assign in_pair0  = (state == LOAD0) | (state == STORE0);
  assign in_pair1  = (state == LOAD1) | (state == STORE1);
  assign odd_tail  = in_pair0 & (woffset1 == vl_q);
  assign final_hit = dhit & (odd_tail | (in_pair1 & last_pair));

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state <= IDLE;
      sew_q <= SEW8;
      vl_q  <= '0;
    end
    else
    begin
      state <= next_state;
      if ((state == IDLE) && start)
      begin
        sew_q <= sew; // width and length hold for the whole request.
        vl_q  <= vl;
      end
    end
  end

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
      begin
        if (start)
        begin
          if (mis_first)
            next_state = EX; // nothing gets issued for a bad first pair.
          else if (is_store)
            next_state = STORE0;
          else
            next_state = LOAD0;
        end
      end
      LOAD0:
        if (dhit) next_state = odd_tail ? IDLE : LOAD1;
      STORE0:
        if (dhit) next_state = odd_tail ? IDLE : STORE1;
      LOAD1:
      begin
        if (dhit)
          next_state = last_pair ? IDLE : (mis_next ? EX : LOAD0);
      end
      STORE1:
      begin
        if (dhit)
          next_state = last_pair ? IDLE : (mis_next ? EX : STORE0);
      end
      EX:
        if (exc_ack) next_state = IDLE; // the core has taken the trap.
      default:
        next_state = IDLE;
    endcase
  end

  assign ren          = (state == LOAD0) | (state == LOAD1);
  assign wen          = (state == STORE0) | (state == STORE1);
  assign elem_sel     = in_pair1;
  assign dcache_addr  = elem_sel ? addr1 : addr0; // address of the element on the port.
  assign arrived      = ren & dhit;               // read data is valid in this cycle.
  assign pair_advance = in_pair1 & dhit;          // the pair is finished, move on.
  assign busy         = (ren | wen) & ~final_hit; // drops already in the cycle of the last dhit.
  assign exception    = (state == EX);

endmodule

// File: vlsu_load_collect.sv
`timescale 1ns/1ps

module vlsu_load_collect (
  input  logic [vlsu_pkg::DATA_W-1:0] rdata,
  input  logic [vlsu_pkg::ADDR_W-1:0] dcache_addr,
  input  vlsu_pkg::sew_t              sew_q,
  input  logic                        arrived,
  input  logic                        elem_sel,
  input  logic [vlsu_pkg::VL_W-1:0]   woffset0,
  output logic                        vd_wen,
  output logic [vlsu_pkg::VL_W-1:0]   vd_idx,
  output logic [vlsu_pkg::DATA_W-1:0] vd_wdata
);

  import vlsu_pkg::*;

  logic [4:0]        shamt; // bit position of the element's first byte in the word.
  logic [DATA_W-1:0] lane;  // read word with the element moved down to bit 0.

  // the byte offset in the address picks the lane, and alignment keeps the element inside it.
  assign shamt = {dcache_addr[1:0], 3'b000};
  assign lane  = rdata >> shamt;

  // keep only sew bits and fill the rest with zeros.
  always_comb
  begin
    case (sew_q)
      SEW8:
        vd_wdata = {{(DATA_W-8){1'b0}}, lane[7:0]};
      SEW16:
        vd_wdata = {{(DATA_W-16){1'b0}}, lane[15:0]};
      default:
        vd_wdata = lane; // a full word needs no masking.
    endcase
  end

  // the write goes out in the same cycle as the dhit that brought the data.
  assign vd_wen = arrived;

  // destination index is the element number inside the vector.
  assign vd_idx = woffset0 + VL_W'(elem_sel);

endmodule

// File: vlsu_pkg.sv
package vlsu_pkg;

  // address width of the data-cache port.
  localparam int ADDR_W = 32;

  // data width of the cache port and of one destination register element.
  localparam int DATA_W = 32;

  // largest vector length that one request may carry.
  localparam int VLMAX = 8;

  // vl and the element offsets must also hold the value VLMAX itself.
  localparam int VL_W = 4;

  // bits needed to select one element out of the flattened store vector.
  localparam int ELEM_IDX_W = $clog2(VLMAX);

  // element width encoding.
  // only the three integer widths of an RV32 core are supported.
  typedef enum logic [1:0] {
    SEW8  = 2'd0, // one byte per element.
    SEW16 = 2'd1, // one halfword per element.
    SEW32 = 2'd2  // one full word per element.
  } sew_t;

  // scheduler states.
  // state 0 handles the even element of a pair and state 1 the odd one.
  typedef enum logic [2:0] {
    IDLE   = 3'd0, // waiting for a start pulse.
    LOAD0  = 3'd1, // read of the even element.
    LOAD1  = 3'd2, // read of the odd element.
    STORE0 = 3'd3, // write of the even element.
    STORE1 = 3'd4, // write of the odd element.
    EX     = 3'd5  // misaligned element seen, wait for the core to acknowledge.
  } sched_state_t;

endpackage

// File: vlsu_props.sv
`timescale 1ns/1ps

module vlsu_props (
  input logic                        CLK,
  input logic                        nRST,
  input vlsu_pkg::sched_state_t      state,
  input logic                        ren,
  input logic                        wen,
  input logic                        busy,
  input logic                        exception,
  input logic                        dhit,
  input logic [vlsu_pkg::ADDR_W-1:0] dcache_addr
);

  // there is one access at a time and it is either a read or a write.
  strobe_exclusive: assert property (@(posedge CLK) disable iff (!nRST) !(ren && wen))
    else $error("ren and wen are high in the same cycle");

  // a waiting access keeps its state, strobe and address until dhit completes it.
  addr_held: assert property (@(posedge CLK) disable iff (!nRST)
    (ren || wen) && !dhit |=> $stable(state) && $stable(dcache_addr))
    else $error("cache access changed before dhit");

  // the trap state is never busy.
  exc_not_busy: assert property (@(posedge CLK) disable iff (!nRST)
    exception |-> !busy)
    else $error("exception raised while busy");

endmodule

bind vlsu_address_scheduler vlsu_props u_props (
  .CLK(CLK),
  .nRST(nRST),
  .state(state),
  .ren(ren),
  .wen(wen),
  .busy(busy),
  .exception(exception),
  .dhit(dhit),
  .dcache_addr(dcache_addr)
);

// File: vlsu_store_pack.sv
`timescale 1ns/1ps

module vlsu_store_pack (
  input  logic [vlsu_pkg::VLMAX*vlsu_pkg::DATA_W-1:0] st_vec,
  input  logic [vlsu_pkg::ADDR_W-1:0]                 dcache_addr,
  input  vlsu_pkg::sew_t                              sew_q,
  input  logic [vlsu_pkg::VL_W-1:0]                   woffset0,
  input  logic                                        elem_sel,
  output logic [vlsu_pkg::DATA_W-1:0]                 dcache_wdata,
  output logic [3:0]                                  dcache_byte_en
);

  import vlsu_pkg::*;

  logic [VL_W-1:0]   elem_idx; // element number of the access on the port.
  logic [DATA_W-1:0] elem;     // raw 32-bit slot from the store vector.
  logic [DATA_W-1:0] elem_ext; // element with bits above sew cleared.
  logic [3:0]        size_en;  // byte enables for an element sitting at byte 0.
  logic [4:0]        shamt;

  assign elem_idx = woffset0 + VL_W'(elem_sel);

  // st_vec holds element i in bits 32*i+31 down to 32*i.
  // An index past VLMAX never reaches the port, so the low bits are enough.
  assign elem = st_vec[elem_idx[ELEM_IDX_W-1:0]*DATA_W +: DATA_W];

  always_comb
  begin
    case (sew_q)
      SEW8:
      begin
        elem_ext = {{(DATA_W-8){1'b0}}, elem[7:0]};
        size_en  = 4'b0001;
      end
      SEW16:
      begin
        elem_ext = {{(DATA_W-16){1'b0}}, elem[15:0]};
        size_en  = 4'b0011;
      end
      default:
      begin
        elem_ext = elem;
        size_en  = 4'b1111; // whole word.
      end
    endcase
  end

  // move the element up to its byte lane.
  // The enables follow, so bytes outside the element stay untouched in memory.
  assign shamt          = {dcache_addr[1:0], 3'b000};
  assign dcache_wdata   = elem_ext << shamt;
  assign dcache_byte_en = size_en << dcache_addr[1:0];

endmodule

// File: vlsu_top.sv
`timescale 1ns/1ps

module vlsu_top (
  input  logic                                        CLK,
  input  logic                                        nRST,
  input  logic                                        start,
  input  logic                                        is_store,
  input  logic [vlsu_pkg::ADDR_W-1:0]                 base_addr,
  input  logic [vlsu_pkg::ADDR_W-1:0]                 stride,
  input  vlsu_pkg::sew_t                              sew,
  input  logic [vlsu_pkg::VL_W-1:0]                   vl,
  input  logic [vlsu_pkg::VLMAX*vlsu_pkg::DATA_W-1:0] st_vec,
  input  logic                                        exc_ack,
  input  logic                                        dhit,
  input  logic [vlsu_pkg::DATA_W-1:0]                 rdata,
  output logic                                        busy,
  output logic                                        exception,
  output logic [vlsu_pkg::ADDR_W-1:0]                 dcache_addr,
  output logic [vlsu_pkg::DATA_W-1:0]                 dcache_wdata,
  output logic [3:0]                                  dcache_byte_en,
  output logic                                        ren,
  output logic                                        wen,
  output logic                                        vd_wen,
  output logic [vlsu_pkg::VL_W-1:0]                   vd_idx,
  output logic [vlsu_pkg::DATA_W-1:0]                 vd_wdata
);

  import vlsu_pkg::*;

  logic [ADDR_W-1:0] addr0, addr1;
  logic [VL_W-1:0]   woffset0, woffset1;
  logic              last_pair, pair_advance, elem_sel, arrived;
  sew_t              sew_q;
  logic              start_acc; // start that the stage will actually take.

  // a request is taken only with no access on the port and no pending exception.
  // That is exactly the idle state, so a start in flight cannot disturb the addresses.
  assign start_acc = start & ~(ren | wen | exception);

  vlsu_addr_gen u_addr_gen (
    .CLK(CLK), .nRST(nRST), .start(start_acc), .base_addr(base_addr), .stride(stride),
    .vl(vl), .pair_advance(pair_advance), .addr0(addr0), .addr1(addr1),
    .woffset0(woffset0), .woffset1(woffset1), .last_pair(last_pair)
  );

  vlsu_address_scheduler u_sched (
    .CLK(CLK), .nRST(nRST), .start(start_acc), .is_store(is_store), .sew(sew), .vl(vl),
    .addr0(addr0), .addr1(addr1), .woffset1(woffset1), .last_pair(last_pair),
    .dhit(dhit), .exc_ack(exc_ack), .dcache_addr(dcache_addr), .ren(ren), .wen(wen),
    .busy(busy), .exception(exception), .arrived(arrived), .elem_sel(elem_sel),
    .pair_advance(pair_advance), .sew_q(sew_q)
  );

  vlsu_load_collect u_load (
    .rdata(rdata), .dcache_addr(dcache_addr), .sew_q(sew_q), .arrived(arrived),
    .elem_sel(elem_sel), .woffset0(woffset0), .vd_wen(vd_wen), .vd_idx(vd_idx),
    .vd_wdata(vd_wdata)
  );

  vlsu_store_pack u_store (
    .st_vec(st_vec), .dcache_addr(dcache_addr), .sew_q(sew_q), .woffset0(woffset0),
    .elem_sel(elem_sel), .dcache_wdata(dcache_wdata), .dcache_byte_en(dcache_byte_en)
  );

endmodule
